// File: compile.f
+incdir+include
logic/ram_pkg.sv
logic/mem_if.sv
logic/mem_port_ctrl.sv
logic/mem_lane.sv
logic/mem_rd_merge.sv
logic/ram.sv
tb/ram_asserts.sv
tb/ram_tb.sv

// File: include/ram_settings.svh
// ##############################
// data memory build settings
// widths, depth, lane count and window base
// ##############################
`ifndef RAM_SETTINGS_SVH
`define RAM_SETTINGS_SVH

// core data and address widths
`define RAM_DATA_W 64
`define RAM_ADDR_W 64

// one storage lane per byte of a doubleword
`define RAM_LANES 8

// 512 doublewords, a 4 KB window
`define RAM_WORDS 512
`define RAM_IDX_W 9

// first byte address of the window
`define RAM_BASE 64'h0000_0000_8000_0000

`endif

// File: logic/mem_if.sv
// ##############################
// lane_req_if  controller to lanes
// lane_rsp_if  lanes and controller to merger
// ##############################

interface lane_req_if;

    // write side, already gated and decoded
    ram_pkg::word_idx_t wr_idx;
    ram_pkg::dword_t    wr_data;
    // one strobe per lane, zero when the write is dropped
    ram_pkg::bmask_t    wr_bytes;

    // read side, one strobe for all lanes
    ram_pkg::word_idx_t rd_idx;
    logic               rd_en;

    modport ctrl (
        output wr_idx, wr_data, wr_bytes, rd_idx, rd_en
    );

    modport lane (
        input wr_idx, wr_data, wr_bytes, rd_idx, rd_en
    );

endinterface

interface lane_rsp_if;

    // each lane drives its own byte of this word
    wire ram_pkg::dword_t lane_q;

    // forwarding info for a same-cycle read and write
    ram_pkg::bmask_t fwd_mask;
    ram_pkg::dword_t fwd_data;

    // a read was accepted one edge earlier
    logic rd_valid;
    // that read hit the window
    logic rd_in_range;

    modport ctrl (
        output fwd_mask, fwd_data, rd_valid, rd_in_range
    );

    modport lane (
        output lane_q
    );

    modport merge (
        input lane_q, fwd_mask, fwd_data, rd_valid, rd_in_range
    );

endinterface

// File: logic/mem_lane.sv
// ##############################
// one byte lane of the data memory
// sync write, registered read
// ##############################
`include "ram_settings.svh"

module mem_lane #(
    // lane number, 0 to `RAM_LANES-1
    parameter int unsigned LANE = 0
) (
    input logic      clk,
    lane_req_if.lane req,
    lane_rsp_if.lane rsp
);

    localparam int unsigned BYTE_W = $bits(ram_pkg::byte_t);

    // storage for this lane's byte of every doubleword
    ram_pkg::byte_t mem [`RAM_WORDS];
    // read register, holds between reads
    ram_pkg::byte_t q;

    // own strobe, own byte slice of the write word
    always_ff @(posedge clk) begin
        if (req.wr_bytes[LANE]) begin
            mem[req.wr_idx] <= req.wr_data[LANE*BYTE_W +: BYTE_W];
        end
    end

    // old data on a same-cycle write
    // the merger patches in the new byte
    always_ff @(posedge clk) begin
        if (req.rd_en) begin
            q <= mem[req.rd_idx];
        end
    end

    assign rsp.lane_q[LANE*BYTE_W +: BYTE_W] = q;

endmodule

// File: logic/mem_port_ctrl.sv
// ##############################
// data memory port controller
// acceptance, window decode, collision
// and registered forwarding info
// ##############################
`include "ram_settings.svh"

module mem_port_ctrl (
    input  logic             clk,
    input  logic             rst_i,
    input  logic             hold_flag_i,
    // write request from execute
    input  logic             mem_wen_i,
    input  ram_pkg::addr_t   mem_waddr_i,
    input  ram_pkg::dword_t  mem_wdata_i,
    input  ram_pkg::bmask_t  mem_wmask_i,
    // read request from decode
    input  logic             mem_ren_i,
    input  ram_pkg::addr_t   mem_raddr_i,
    lane_req_if.ctrl         req,
    lane_rsp_if.ctrl         rsp
);

    // low address bits that pick a byte inside a doubleword
    localparam int unsigned BYTE_SEL_W = $clog2(`RAM_LANES);
    // byte offset bits that span the whole window
    localparam int unsigned WIN_W = `RAM_IDX_W + BYTE_SEL_W;
    localparam ram_pkg::addr_t BASE = `RAM_BASE;

    ram_pkg::addr_t     w_off;
    ram_pkg::addr_t     r_off;
    ram_pkg::word_idx_t w_idx;
    ram_pkg::word_idx_t r_idx;
    logic               w_in_win;
    logic               r_in_win;
    logic               wr_acc;
    logic               rd_acc;
    logic               collide;

    // offsets from the base, wrap below the base lands out of window
    assign w_off = mem_waddr_i - BASE;
    assign r_off = mem_raddr_i - BASE;

    // in window when nothing above the window bits is set
    assign w_in_win = (w_off[`RAM_ADDR_W-1:WIN_W] == '0);
    assign r_in_win = (r_off[`RAM_ADDR_W-1:WIN_W] == '0);

    // doubleword index, byte select bits dropped
    assign w_idx = w_off[WIN_W-1:BYTE_SEL_W];
    assign r_idx = r_off[WIN_W-1:BYTE_SEL_W];

    // hold blocks both ports
    // out of window writes are dropped here
    assign wr_acc = mem_wen_i && !hold_flag_i && w_in_win;
    // range only decides data or zero later on
    assign rd_acc = mem_ren_i && !hold_flag_i;

    // same doubleword read and written this cycle
    assign collide = wr_acc && rd_acc && r_in_win && (r_idx == w_idx);

    // lane side requests
    assign req.wr_idx   = w_idx;
    assign req.wr_data  = mem_wdata_i;
    assign req.wr_bytes = wr_acc ? mem_wmask_i : '0;
    assign req.rd_idx   = r_idx;
    // lanes only fetch for reads that hit the window
    assign req.rd_en    = rd_acc && r_in_win;

    // read tracking and forwarding mask, one edge behind the request
    always_ff @(posedge clk) begin
        if (rst_i) begin
            rsp.rd_valid    <= 1'b0;
            rsp.rd_in_range <= 1'b0;
            rsp.fwd_mask    <= '0;
        end else begin
            rsp.rd_valid    <= rd_acc;
            rsp.rd_in_range <= r_in_win;
            rsp.fwd_mask    <= collide ? mem_wmask_i : '0;
        end
    end

    // forwarded bytes, only looked at under fwd_mask
    always_ff @(posedge clk) begin
        rsp.fwd_data <= mem_wdata_i;
    end

endmodule

// File: logic/mem_rd_merge.sv
// ##############################
// read merger
// lane data, forwarded bytes or zero
// into the held read word
// ##############################
`include "ram_settings.svh"

module mem_rd_merge (
    input  logic            clk,
    input  logic            rst_i,
    lane_rsp_if.merge       rsp,
    output ram_pkg::dword_t mem_rdata_o
);

    localparam int unsigned BYTE_W = $bits(ram_pkg::byte_t);

    ram_pkg::dword_t merged;

    // byte-wise pick between the write of the same cycle and storage
    always_comb begin
        for (int k = 0; k < `RAM_LANES; k++) begin
            if (rsp.fwd_mask[k]) begin
                merged[k*BYTE_W +: BYTE_W] = rsp.fwd_data[k*BYTE_W +: BYTE_W];
            end else begin
                merged[k*BYTE_W +: BYTE_W] = rsp.lane_q[k*BYTE_W +: BYTE_W];
            end
        end
        // reads outside the window return zero
        if (!rsp.rd_in_range) begin
            merged = '0;
        end
    end

    // second edge of the read, held until the next read lands
    always_ff @(posedge clk) begin
        if (rst_i) begin
            mem_rdata_o <= '0;
        end else if (rsp.rd_valid) begin
            mem_rdata_o <= merged;
        end
    end

endmodule

// File: logic/ram.sv
// ##############################
// data memory top level
// controller, byte lanes, read merger
// ##############################
`include "ram_settings.svh"

module ram (
    input  logic            clk,
    input  logic            rst_i,

    // stall from the pipeline
    input  logic            hold_flag_i,

    // from ex
    input  logic            mem_wen_i,
    input  ram_pkg::addr_t  mem_waddr_i,
    input  ram_pkg::dword_t mem_wdata_i,
    input  ram_pkg::bmask_t mem_wmask_i,

    // from id
    input  logic            mem_ren_i,
    input  ram_pkg::addr_t  mem_raddr_i,

    // to ex, two edges after an accepted read
    output ram_pkg::dword_t mem_rdata_o
);

    lane_req_if req_if ();
    lane_rsp_if rsp_if ();

    // request side decode and forwarding
    mem_port_ctrl u_ctrl (
        .clk         (clk),
        .rst_i       (rst_i),
        .hold_flag_i (hold_flag_i),
        .mem_wen_i   (mem_wen_i),
        .mem_waddr_i (mem_waddr_i),
        .mem_wdata_i (mem_wdata_i),
        .mem_wmask_i (mem_wmask_i),
        .mem_ren_i   (mem_ren_i),
        .mem_raddr_i (mem_raddr_i),
        .req         (req_if),
        .rsp         (rsp_if)
    );

    // one storage lane per byte
    for (genvar g = 0; g < `RAM_LANES; g++) begin : g_lane
        mem_lane #(
            .LANE (g)
        ) u_lane (
            .clk (clk),
            .req (req_if),
            .rsp (rsp_if)
        );
    end

    // output word assembly
    mem_rd_merge u_merge (
        .clk         (clk),
        .rst_i       (rst_i),
        .rsp         (rsp_if),
        .mem_rdata_o (mem_rdata_o)
    );

endmodule

// File: logic/ram_pkg.sv
// ##############################
// data memory types
// addresses, words, bytes, masks, indices
// ##############################
`include "ram_settings.svh"

package ram_pkg;

    // byte address as issued by the core
    typedef logic [`RAM_ADDR_W-1:0] addr_t;

    // one doubleword of data
    typedef logic [`RAM_DATA_W-1:0] dword_t;

    // the slice held by a single lane
    typedef logic [`RAM_DATA_W/`RAM_LANES-1:0] byte_t;

    // bit k selects byte k of a doubleword
    typedef logic [`RAM_LANES-1:0] bmask_t;

    // doubleword index inside the window
    typedef logic [`RAM_IDX_W-1:0] word_idx_t;

endpackage

// File: run.sh
#!/usr/bin/env bash
# build the data memory testbench with verilator and run it
# the exit status of the simulation decides pass or fail
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -j 0 \
    -f compile.f \
    --top-module ram_tb \
    -Mdir obj_dir \
    && ./obj_dir/Vram_tb \
    || { echo "build or simulation returned an error"; exit 1; }

// File: tb/ram_asserts.sv
// ##############################
// concurrent checks on the port controller
// bound into every mem_port_ctrl
// ##############################

module ram_asserts (
    input logic            clk,
    input logic            rst_i,
    input logic            hold_flag_i,
    input logic            mem_wen_i,
    input logic            mem_ren_i,
    // registered read tracking from the controller
    input logic            rd_valid,
    input ram_pkg::bmask_t fwd_mask
);

    // a read requested under hold never becomes valid
    hold_blocks_read: assert property (
        @(posedge clk) disable iff (rst_i) hold_flag_i |=> !rd_valid
    ) else $error("read went valid after a cycle with hold high");

    // forwarding only follows a read and a write in one unheld cycle
    fwd_needs_pair: assert property (
        @(posedge clk) disable iff (rst_i)
        (fwd_mask != '0) |-> $past(mem_wen_i && mem_ren_i && !hold_flag_i)
    ) else $error("forwarding mask set without a same-cycle read and write");

    // reset clears the read tracking
    reset_clears_valid: assert property (
        @(posedge clk) rst_i |=> !rd_valid
    ) else $error("read still valid right after reset");

endmodule

bind mem_port_ctrl ram_asserts u_asserts (
    .clk         (clk),
    .rst_i       (rst_i),
    .hold_flag_i (hold_flag_i),
    .mem_wen_i   (mem_wen_i),
    .mem_ren_i   (mem_ren_i),
    .rd_valid    (rsp.rd_valid),
    .fwd_mask    (rsp.fwd_mask)
);

// File: tb/ram_tb.sv
// ##############################
// data memory testbench
// clock, reset, reference model, watchdog
// directed tests and a seeded random run
// ##############################
`include "ram_settings.svh"

module ram_tb;

    localparam int RESET_CYCLES = 10;
    localparam int RAND_WORDS = 16;
    localparam int RAND_OPS = 200;
    // upper bound on directed requests, two edges each
    localparam int DIRECTED_REQS = 40;
    localparam int RUN_CYCLES = RESET_CYCLES + 2 * (DIRECTED_REQS + RAND_WORDS + RAND_OPS);
    localparam int MARGIN = 100;
    localparam ram_pkg::addr_t BASE = `RAM_BASE;
    localparam ram_pkg::addr_t WIN_BYTES = 64'(`RAM_WORDS * 8);

    logic            clk = 1'b0;
    logic            rst_i;
    logic            hold_flag_i;
    logic            mem_wen_i;
    ram_pkg::addr_t  mem_waddr_i;
    ram_pkg::dword_t mem_wdata_i;
    ram_pkg::bmask_t mem_wmask_i;
    logic            mem_ren_i;
    ram_pkg::addr_t  mem_raddr_i;
    ram_pkg::dword_t mem_rdata_o;

    // reference storage, word index to doubleword
    ram_pkg::dword_t model [int];
    // word the read port should show right now
    ram_pkg::dword_t rd_expect;
    int seed = 13230;

    ram ram_i (
        .clk         (clk),
        .rst_i       (rst_i),
        .hold_flag_i (hold_flag_i),
        .mem_wen_i   (mem_wen_i),
        .mem_waddr_i (mem_waddr_i),
        .mem_wdata_i (mem_wdata_i),
        .mem_wmask_i (mem_wmask_i),
        .mem_ren_i   (mem_ren_i),
        .mem_raddr_i (mem_raddr_i),
        .mem_rdata_o (mem_rdata_o)
    );

    always #5 clk = ~clk;

    // 4 KB window starting at the base
    function automatic logic in_window(input ram_pkg::addr_t a);
        return (a >= BASE) && (a < BASE + WIN_BYTES);
    endfunction

    // low three bits ignored
    function automatic int word_index(input ram_pkg::addr_t a);
        return int'((a - BASE) >> 3);
    endfunction

    function automatic ram_pkg::dword_t merge_bytes(input ram_pkg::dword_t old_w,
                                                    input ram_pkg::dword_t new_w,
                                                    input ram_pkg::bmask_t mask);
        ram_pkg::dword_t res;
        res = old_w;
        for (int k = 0; k < 8; k++) begin
            if (mask[k]) begin
                res[k*8 +: 8] = new_w[k*8 +: 8];
            end
        end
        return res;
    endfunction

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_word(input string test, input ram_pkg::dword_t exp);
        assert (mem_rdata_o === exp) else begin
            stop_run($sformatf("MISMATCH %s expected %h actual %h", test, exp, mem_rdata_o));
        end
    endtask

    task automatic idle_inputs();
        hold_flag_i = 1'b0;
        mem_wen_i   = 1'b0;
        mem_waddr_i = '0;
        mem_wdata_i = '0;
        mem_wmask_i = '0;
        mem_ren_i   = 1'b0;
        mem_raddr_i = '0;
    endtask

    // one request cycle, then one idle cycle, then the read port check
    task automatic issue(input string test, input logic hold, input logic wen,
                         input ram_pkg::addr_t waddr, input ram_pkg::dword_t wdata,
                         input ram_pkg::bmask_t wmask, input logic ren,
                         input ram_pkg::addr_t raddr);
        int widx;
        int ridx;
        ram_pkg::dword_t old_w;
        widx = word_index(waddr);
        ridx = word_index(raddr);
        // read sees storage before this cycle's write, plus forwarded bytes
        if (ren && !hold) begin
            if (!in_window(raddr)) begin
                rd_expect = '0;
            end else if (!model.exists(ridx)) begin
                stop_run("test reads a doubleword it never wrote");
            end else begin
                rd_expect = model[ridx];
                if (wen && in_window(waddr) && (widx == ridx)) begin
                    rd_expect = merge_bytes(rd_expect, wdata, wmask);
                end
            end
        end
        if (wen && !hold && in_window(waddr)) begin
            old_w = model.exists(widx) ? model[widx] : '0;
            model[widx] = merge_bytes(old_w, wdata, wmask);
        end
        hold_flag_i = hold;
        mem_wen_i   = wen;
        mem_waddr_i = waddr;
        mem_wdata_i = wdata;
        mem_wmask_i = wmask;
        mem_ren_i   = ren;
        mem_raddr_i = raddr;
        @(posedge clk);
        #1;
        idle_inputs();
        @(posedge clk);
        #1;
        check_word(test, rd_expect);
    endtask

    task automatic write_word(input string test, input ram_pkg::addr_t a,
                              input ram_pkg::dword_t d, input ram_pkg::bmask_t m);
        issue(test, 1'b0, 1'b1, a, d, m, 1'b0, '0);
    endtask

    task automatic read_word(input string test, input ram_pkg::addr_t a);
        issue(test, 1'b0, 1'b0, '0, '0, '0, 1'b1, a);
    endtask

    // first, second, middle and last doubleword of the window
    task automatic test_full_words();
        ram_pkg::addr_t addrs [4];
        addrs = '{BASE, BASE + 64'h8, BASE + 64'h800, BASE + 64'hff8};
        for (int i = 0; i < 4; i++) begin
            write_word("full_words", addrs[i], {addrs[i][31:0], ~addrs[i][31:0]}, 8'hff);
        end
        for (int i = 0; i < 4; i++) begin
            read_word("full_words", addrs[i]);
        end
        // byte offset inside the doubleword is dropped
        read_word("full_words", BASE + 64'hd);
    endtask

    task automatic test_partial_masks();
        write_word("partial_masks", BASE + 64'h10, 64'h0011_2233_4455_6677, 8'hff);
        write_word("partial_masks", BASE + 64'h10, 64'h8899_aabb_ccdd_eeff, 8'h0f);
        read_word("partial_masks", BASE + 64'h10);
        write_word("partial_masks", BASE + 64'h10, 64'h5a5a_5a5a_5a5a_5a5a, 8'ha5);
        read_word("partial_masks", BASE + 64'h10);
        write_word("partial_masks", BASE + 64'h10, 64'hee00_0000_0000_0000, 8'h80);
        read_word("partial_masks", BASE + 64'h10);
    endtask

    task automatic test_same_cycle();
        write_word("same_cycle", BASE + 64'h20, 64'h1111_2222_3333_4444, 8'hff);
        write_word("same_cycle", BASE + 64'h28, 64'h5555_6666_7777_8888, 8'hff);
        // collision, new bytes only under the mask
        issue("same_cycle", 1'b0, 1'b1, BASE + 64'h20, 64'hfedc_ba98_7654_3210, 8'h3c,
              1'b1, BASE + 64'h20);
        read_word("same_cycle", BASE + 64'h20);
        // different doublewords stay apart
        issue("same_cycle", 1'b0, 1'b1, BASE + 64'h28, 64'h0f0f_0f0f_f0f0_f0f0, 8'hff,
              1'b1, BASE + 64'h20);
        read_word("same_cycle", BASE + 64'h28);
    endtask

    task automatic test_hold();
        read_word("hold", BASE + 64'h20);
        issue("hold", 1'b1, 1'b1, BASE + 64'h20, 64'hdead_beef_dead_beef, 8'hff,
              1'b1, BASE + 64'h28);
        issue("hold", 1'b1, 1'b0, '0, '0, '0, 1'b1, BASE + 64'h10);
        read_word("hold", BASE + 64'h20);
    endtask

    // just past the top, and just below the base
    task automatic test_out_of_window();
        write_word("out_of_window", BASE + WIN_BYTES, 64'hbad0_bad0_bad0_bad0, 8'hff);
        write_word("out_of_window", BASE - 64'h8, 64'hbad1_bad1_bad1_bad1, 8'hff);
        read_word("out_of_window", BASE);
        read_word("out_of_window", BASE + 64'hff8);
        read_word("out_of_window", BASE + WIN_BYTES);
        read_word("out_of_window", 64'h0);
    endtask

    task automatic test_random();
        logic hold;
        logic wen;
        logic ren;
        ram_pkg::addr_t waddr;
        ram_pkg::addr_t raddr;
        // every word in play gets a known value first
        for (int i = 0; i < RAND_WORDS; i++) begin
            write_word("random", BASE + 64'(i * 8), {$random(seed), $random(seed)}, 8'hff);
        end
        for (int i = 0; i < RAND_OPS; i++) begin
            hold  = (($random(seed) & 3) == 0);
            wen   = (($random(seed) & 1) != 0);
            ren   = (($random(seed) & 1) != 0);
            waddr = BASE + 64'(($random(seed) & (RAND_WORDS - 1)) * 8) + 64'($random(seed) & 7);
            raddr = BASE + 64'(($random(seed) & (RAND_WORDS - 1)) * 8) + 64'($random(seed) & 7);
            issue("random", hold, wen, waddr, {$random(seed), $random(seed)},
                  8'($random(seed)), ren, raddr);
        end
    endtask

    initial begin
        rst_i = 1'b1;
        idle_inputs();
        rd_expect = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_i = 1'b0;
        check_word("reset", '0);
        test_full_words();
        test_partial_masks();
        test_same_cycle();
        test_hold();
        test_out_of_window();
        test_random();
        $display("Regression passed");
        $finish;
    end

    // bound from the request count of all tests
    initial begin
        repeat (RUN_CYCLES + MARGIN) @(posedge clk);
        stop_run("timeout, the tests did not finish in time");
    end

endmodule
